// ==== include/systolic_macros.svh ====
`ifndef SYSTOLIC_MACROS_SVH
`define SYSTOLIC_MACROS_SVH

// matrix dimension, also the grid size
`define MM_SIZE 4

// signed operand and result width
`define MM_DWIDTH 8

// accumulator width, wide enough for four full-scale products
`define MM_ACCW 18

// operand flop, product register, accumulator
`define MM_MAC_STAGES 3

`endif

// ==== src/systolic_pkg.sv ====
`include "systolic_macros.svh"

package systolic_pkg;

    // clamp a wide signed sum into the signed result range
    function automatic logic [`MM_DWIDTH-1:0] sat_down(input logic signed [`MM_ACCW-1:0] v);
        logic signed [`MM_ACCW-1:0] hi;
        logic signed [`MM_ACCW-1:0] lo;
        hi = `MM_ACCW'(2 ** (`MM_DWIDTH - 1) - 1);
        lo = -hi - 1;
        if (v > hi)
            return {1'b0, {(`MM_DWIDTH-1){1'b1}}};
        if (v < lo)
            return {1'b1, {(`MM_DWIDTH-1){1'b0}}};
        return v[`MM_DWIDTH-1:0];
    endfunction

    // cycles from the last accepted beat until the far corner cell has summed it
    function automatic int flush_cycles();
        return 1 + (`MM_SIZE - 1) + 2 * (`MM_SIZE - 1) + `MM_MAC_STAGES;
    endfunction

endpackage

// ==== src/operand_skew.sv ====
`timescale 1ns/1ps
`include "systolic_macros.svh"

module operand_skew (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            i_valid,
    input  logic [`MM_SIZE*`MM_DWIDTH-1:0]  i_a_col,
    input  logic [`MM_SIZE*`MM_DWIDTH-1:0]  i_b_row,
    output logic [`MM_SIZE*`MM_DWIDTH-1:0]  o_a_lanes,
    output logic [`MM_SIZE*`MM_DWIDTH-1:0]  o_b_lanes
);
    import systolic_pkg::*;

    localparam int DW        = `MM_DWIDTH;
    localparam int FLUSH_LEN = flush_cycles();

    logic [`MM_SIZE*DW-1:0] a_q;  // beat register, zero between beats
    logic [`MM_SIZE*DW-1:0] b_q;

    always_ff @(posedge clk) begin
        if (reset || !i_valid) begin
            a_q <= '0;
            b_q <= '0;
        end else begin
            a_q <= i_a_col;
            b_q <= i_b_row;
        end
    end

    // lane k waits k extra cycles so A[r][k] and B[k][c] meet in cell (r,c)
    for (genvar k = 0; k < `MM_SIZE; k++) begin : g_lane
        if (k == 0) begin : g_direct
            assign o_a_lanes[k*DW +: DW] = a_q[k*DW +: DW];
            assign o_b_lanes[k*DW +: DW] = b_q[k*DW +: DW];
        end else begin : g_delay
            logic [DW-1:0] a_sr [k];
            logic [DW-1:0] b_sr [k];

            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int i = 0; i < k; i++) begin
                        a_sr[i] <= '0;
                        b_sr[i] <= '0;
                    end
                end else begin
                    a_sr[0] <= a_q[k*DW +: DW];
                    b_sr[0] <= b_q[k*DW +: DW];
                    for (int i = 1; i < k; i++) begin
                        a_sr[i] <= a_sr[i-1];
                        b_sr[i] <= b_sr[i-1];
                    end
                end
            end

            assign o_a_lanes[k*DW +: DW] = a_sr[k-1];
            assign o_b_lanes[k*DW +: DW] = b_sr[k-1];
        end
    end

    // a beat must be clean, and the lanes stay clean while it drains through the grid
    a_beat_known: assert property (@(posedge clk) disable iff (reset)
        i_valid |-> !$isunknown({i_a_col, i_b_row})
            ##1 !$isunknown({o_a_lanes, o_b_lanes}) [*FLUSH_LEN]);

endmodule

// ==== src/processing_element.sv ====
`timescale 1ns/1ps
`include "systolic_macros.svh"

module processing_element (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_clear,
    input  logic [`MM_DWIDTH-1:0]  i_a,
    input  logic [`MM_DWIDTH-1:0]  i_b,
    output logic [`MM_DWIDTH-1:0]  o_a,
    output logic [`MM_DWIDTH-1:0]  o_b,
    output logic [`MM_DWIDTH-1:0]  o_c
);
    import systolic_pkg::*;

    logic signed [`MM_DWIDTH-1:0]   a_f;  // operand flops
    logic signed [`MM_DWIDTH-1:0]   b_f;
    logic signed [2*`MM_DWIDTH-1:0] prod;
    logic signed [`MM_ACCW-1:0]     acc;

    // east and south forwarding, one cycle per hop
    always_ff @(posedge clk) begin
        if (reset) begin
            o_a <= '0;
            o_b <= '0;
        end else begin
            o_a <= i_a;
            o_b <= i_b;
        end
    end

    // three-stage mac: flop operands, register the product, accumulate
    always_ff @(posedge clk) begin
        if (reset) begin
            a_f  <= '0;
            b_f  <= '0;
            prod <= '0;
            acc  <= '0;
        end else begin
            a_f  <= i_a;
            b_f  <= i_b;
            prod <= a_f * b_f;  // full 16-bit signed product
            if (i_clear)
                acc <= '0;
            else
                acc <= acc + `MM_ACCW'(prod);
        end
    end

    assign o_c = sat_down(acc);

    // a clear must win over any product still in flight
    a_clear_zero: assert property (@(posedge clk) disable iff (reset)
        i_clear |=> (acc == '0));

endmodule

// ==== src/systolic_array.sv ====
`timescale 1ns/1ps
`include "systolic_macros.svh"

module systolic_array (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     i_clear,
    input  logic [`MM_SIZE*`MM_DWIDTH-1:0]           i_a_lanes,
    input  logic [`MM_SIZE*`MM_DWIDTH-1:0]           i_b_lanes,
    output logic [`MM_SIZE*`MM_SIZE*`MM_DWIDTH-1:0]  o_c_grid
);
    localparam int N  = `MM_SIZE;
    localparam int DW = `MM_DWIDTH;

    // a_h[r][c] enters cell (r,c) from the west, b_v[r][c] from the north
    logic [DW-1:0] a_h [N][N+1];
    logic [DW-1:0] b_v [N+1][N];

    for (genvar k = 0; k < N; k++) begin : g_edge
        assign a_h[k][0] = i_a_lanes[k*DW +: DW];  // row k of A lanes
        assign b_v[0][k] = i_b_lanes[k*DW +: DW];  // column k of B lanes
    end

    for (genvar r = 0; r < N; r++) begin : g_row
        for (genvar c = 0; c < N; c++) begin : g_col
            processing_element pe_i (
                .clk     (clk),
                .reset   (reset),
                .i_clear (i_clear),
                .i_a     (a_h[r][c]),
                .i_b     (b_v[r][c]),
                .o_a     (a_h[r][c+1]),
                .o_b     (b_v[r+1][c]),
                .o_c     (o_c_grid[(r*N + c)*DW +: DW])  // row-major, row 0 in low bits
            );
        end
    end

endmodule

// ==== src/result_drain.sv ====
`timescale 1ns/1ps
`include "systolic_macros.svh"

module result_drain (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     i_start,
    input  logic                                     i_valid,
    input  logic [`MM_SIZE*`MM_SIZE*`MM_DWIDTH-1:0]  i_c_grid,
    output logic                                     o_clear,
    output logic                                     o_busy,
    output logic                                     o_row_valid,
    output logic [`MM_SIZE*`MM_DWIDTH-1:0]           o_row,
    output logic [$clog2(`MM_SIZE)-1:0]              o_row_idx
);
    import systolic_pkg::*;

    localparam int ROW_W     = `MM_SIZE * `MM_DWIDTH;
    localparam int IDXW      = $clog2(`MM_SIZE);
    localparam int FLUSH_LEN = flush_cycles();
    localparam int FCW       = $clog2(FLUSH_LEN + 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_LOAD  = 2'd1;
    localparam logic [1:0] ST_FLUSH = 2'd2;
    localparam logic [1:0] ST_DRAIN = 2'd3;

    logic [1:0]            state;
    logic [IDXW-1:0]       beat_cnt;
    logic [FCW-1:0]        flush_cnt;
    logic                  capture;
    logic [`MM_SIZE*ROW_W-1:0] c_hold;  // captured grid, row 0 in low bits

    assign o_clear = i_start && (state == ST_IDLE);  // start is ignored while busy
    assign o_busy  = (state != ST_IDLE);
    assign capture = (state == ST_FLUSH) && (flush_cnt == FCW'(FLUSH_LEN));
    assign o_row   = c_hold[ROW_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IDLE;
            beat_cnt    <= '0;
            flush_cnt   <= '0;
            o_row_valid <= 1'b0;
            o_row_idx   <= '0;
        end else begin
            case (state)
                ST_IDLE: if (o_clear) begin
                    state    <= ST_LOAD;
                    beat_cnt <= '0;  // beats count from the cycle after start
                end
                ST_LOAD: if (i_valid) begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (beat_cnt == IDXW'(`MM_SIZE - 1)) begin
                        state     <= ST_FLUSH;
                        flush_cnt <= '0;
                    end
                end
                ST_FLUSH: begin
                    flush_cnt <= flush_cnt + 1'b1;
                    if (capture) begin
                        state       <= ST_DRAIN;
                        o_row_valid <= 1'b1;
                        o_row_idx   <= '0;
                    end
                end
                default: begin  // drain, one row per cycle
                    o_row_idx <= o_row_idx + 1'b1;
                    if (o_row_idx == IDXW'(`MM_SIZE - 1)) begin
                        state       <= ST_IDLE;
                        o_row_valid <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture)
            c_hold <= i_c_grid;
        else if (state == ST_DRAIN)
            c_hold <= c_hold >> ROW_W;  // next row into the low bits
    end

    a_row_in_job: assert property (@(posedge clk) disable iff (reset)
        o_row_valid |-> o_busy);

    // a job streams exactly MM_SIZE rows, back to back
    a_row_limit: assert property (@(posedge clk) disable iff (reset)
        $rose(o_row_valid) |-> o_row_valid [*`MM_SIZE] ##1 !o_row_valid);

endmodule

// ==== src/matmul_top.sv ====
`timescale 1ns/1ps
`include "systolic_macros.svh"

module matmul_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            i_start,
    input  logic                            i_valid,
    input  logic [`MM_SIZE*`MM_DWIDTH-1:0]  i_a_col,
    input  logic [`MM_SIZE*`MM_DWIDTH-1:0]  i_b_row,
    output logic                            o_busy,
    output logic                            o_row_valid,
    output logic [`MM_SIZE*`MM_DWIDTH-1:0]  o_row,
    output logic [$clog2(`MM_SIZE)-1:0]     o_row_idx
);
    logic [`MM_SIZE*`MM_DWIDTH-1:0]          a_lanes;
    logic [`MM_SIZE*`MM_DWIDTH-1:0]          b_lanes;
    logic [`MM_SIZE*`MM_SIZE*`MM_DWIDTH-1:0] c_grid;
    logic                                    clear;

    operand_skew skew_i (
        .clk       (clk),
        .reset     (reset),
        .i_valid   (i_valid),
        .i_a_col   (i_a_col),
        .i_b_row   (i_b_row),
        .o_a_lanes (a_lanes),
        .o_b_lanes (b_lanes)
    );

    systolic_array array_i (
        .clk       (clk),
        .reset     (reset),
        .i_clear   (clear),
        .i_a_lanes (a_lanes),
        .i_b_lanes (b_lanes),
        .o_c_grid  (c_grid)
    );

    result_drain drain_i (
        .clk         (clk),
        .reset       (reset),
        .i_start     (i_start),
        .i_valid     (i_valid),
        .i_c_grid    (c_grid),
        .o_clear     (clear),
        .o_busy      (o_busy),
        .o_row_valid (o_row_valid),
        .o_row       (o_row),
        .o_row_idx   (o_row_idx)
    );

endmodule

// ==== bench/tb_matmul.sv ====
`timescale 1ns/1ps
`include "systolic_macros.svh"

module tb_matmul;

    localparam int N           = `MM_SIZE;
    localparam int DW          = `MM_DWIDTH;
    localparam int N_DIRECTED  = 6;
    localparam int N_RANDOM    = 20;
    localparam int N_ENTRIES   = N_DIRECTED + N_RANDOM;
    localparam int MAX_GAP     = 3;
    localparam int FLUSH_EST   = 1 + 3 * (N - 1) + `MM_MAC_STAGES;
    localparam int CYCLE_LIMIT = N_ENTRIES * (N * MAX_GAP + N + FLUSH_EST + N + 10) + 20;

    logic                 clk;
    logic                 reset;
    logic                 i_start;
    logic                 i_valid;
    logic [N*DW-1:0]      i_a_col;
    logic [N*DW-1:0]      i_b_row;
    logic                 o_busy;
    logic                 o_row_valid;
    logic [N*DW-1:0]      o_row;
    logic [$clog2(N)-1:0] o_row_idx;

    logic signed [DW-1:0] a_tab [N_ENTRIES][N][N];
    logic signed [DW-1:0] b_tab [N_ENTRIES][N][N];
    int                   gap_tab [N_ENTRIES][N];  // idle cycles before each beat
    logic                 start_while_busy [N_ENTRIES];

    int exp_c [N][N];  // expected product of the running job
    int rows_seen;
    int cur_entry;
    int errors;
    int cycles;
    int seed;

    matmul_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .i_start     (i_start),
        .i_valid     (i_valid),
        .i_a_col     (i_a_col),
        .i_b_row     (i_b_row),
        .o_busy      (o_busy),
        .o_row_valid (o_row_valid),
        .o_row       (o_row),
        .o_row_idx   (o_row_idx)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // signed byte range, anything outside is pinned to the nearest end
    function automatic int clamp_byte(input int v);
        if (v > 127)
            return 127;
        if (v < -128)
            return -128;
        return v;
    endfunction

    task automatic check_value(input logic signed [31:0] got, input logic signed [31:0] want,
                               input string what);
        if (got !== want) begin
            errors++;
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, want);
        end
    endtask

    task automatic load_expected(input int e);
        int sum;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                sum = 0;
                for (int k = 0; k < N; k++)
                    sum += int'(a_tab[e][r][k]) * int'(b_tab[e][k][c]);
                exp_c[r][c] = clamp_byte(sum);
            end
        end
    endtask

    task automatic build_table();
        for (int e = 0; e < N_ENTRIES; e++) begin
            start_while_busy[e] = 1'b0;
            for (int r = 0; r < N; r++) begin
                gap_tab[e][r] = 0;
                for (int c = 0; c < N; c++) begin
                    case (e)
                        0: begin  // identity times 1..16
                            a_tab[e][r][c] = (r == c) ? DW'(1) : DW'(0);
                            b_tab[e][r][c] = DW'(r * N + c + 1);
                        end
                        1, 4, 5: begin  // mixed signs, small sums
                            a_tab[e][r][c] = ((r + c) % 2 == 1) ? DW'(-(r + 1)) : DW'(c + 2);
                            b_tab[e][r][c] = (r > c) ? DW'(c - 3) : DW'(r + 1);
                        end
                        2: begin
                            a_tab[e][r][c] = DW'(-120);
                            b_tab[e][r][c] = DW'(-110);
                        end
                        3: begin
                            a_tab[e][r][c] = DW'(127);
                            b_tab[e][r][c] = DW'(-128);
                        end
                        default: begin
                            a_tab[e][r][c] = DW'($random(seed));
                            b_tab[e][r][c] = DW'($random(seed));
                        end
                    endcase
                end
                if (e >= N_DIRECTED)
                    gap_tab[e][r] = int'($unsigned($random(seed)) % (MAX_GAP + 1));
            end
        end
        gap_tab[4] = '{2, 0, 3, 1};  // same operands as entry 1, spread out
        gap_tab[5] = '{0, 1, 0, 2};
        start_while_busy[5] = 1'b1;
    endtask

    task automatic run_entry(input int e);
        logic [N*DW-1:0] a_col;
        logic [N*DW-1:0] b_row;
        load_expected(e);
        cur_entry = e;
        rows_seen = 0;
        @(posedge clk);
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        for (int k = 0; k < N; k++) begin
            for (int g = 0; g < gap_tab[e][k]; g++) begin
                i_valid <= 1'b0;
                @(posedge clk);
            end
            for (int i = 0; i < N; i++) begin
                a_col[i*DW +: DW] = a_tab[e][i][k];  // column k of A
                b_row[i*DW +: DW] = b_tab[e][k][i];  // row k of B
            end
            i_valid <= 1'b1;
            i_a_col <= a_col;
            i_b_row <= b_row;
            if (start_while_busy[e] && k == N - 1)
                i_start <= 1'b1;  // must be ignored, partial sums already sit in the grid
            @(posedge clk);
            i_start <= 1'b0;
        end
        i_valid <= 1'b0;
        i_a_col <= '0;
        i_b_row <= '0;
        while (rows_seen < N || o_busy)
            @(negedge clk);
        repeat (2) @(negedge clk);  // room for a stray fifth row
        check_value(rows_seen, N, $sformatf("entry %0d row count", e));
    endtask

    // compare rows as they stream out
    always @(negedge clk) begin
        if (!reset && o_row_valid) begin
            if (rows_seen < N) begin
                check_value(o_row_idx, rows_seen, $sformatf("entry %0d row index", cur_entry));
                for (int c = 0; c < N; c++)
                    check_value($signed(o_row[c*DW +: DW]), exp_c[rows_seen][c],
                                $sformatf("entry %0d C[%0d][%0d]", cur_entry, rows_seen, c));
            end
            rows_seen++;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles with %0d errors so far", cycles, errors);
        $display("Errors found");
        $finish;
    end

    initial begin
        seed      = 21;
        errors    = 0;
        rows_seen = 0;
        cur_entry = 0;
        reset     = 1'b1;
        i_start   = 1'b0;
        i_valid   = 1'b0;
        i_a_col   = '0;
        i_b_row   = '0;
        build_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value(o_busy, 0, "busy after reset");
        check_value(o_row_valid, 0, "row valid after reset");
        for (int e = 0; e < N_ENTRIES; e++)
            run_entry(e);
        $display("%0d errors in %0d jobs", errors, N_ENTRIES);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
src/systolic_pkg.sv
src/operand_skew.sv
src/processing_element.sv
src/systolic_array.sv
src/result_drain.sv
src/matmul_top.sv
bench/tb_matmul.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the matmul testbench with verilator, run it and scan the log
set -u
cd "$(dirname "$0")"

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_matmul --Mdir "$BUILD_DIR" -o tb_matmul
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/tb_matmul" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi
echo "simulation passed"
exit 0
